/* design/bus_noise.sv */
// Open-bus noise, advancing one bit per step
`timescale 1ns/10ps

module bus_noise (
	input  logic           MCLK,
	input  logic           reset,
	input  logic           step,
	output bus_pkg::word_t no_data
);

	logic [16:0] lfsr;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			lfsr    <= bus_pkg::NOISE_SEED;
			no_data <= '0;
		end else if (step) begin
			// XNOR feedback from taps 0 and 2
			lfsr    <= {~(lfsr[0] ^ lfsr[2]), lfsr[16:1]};
			no_data <= {no_data[14:0], lfsr[0]};
		end
	end

endmodule

/* design/bus_pkg.sv */
// Shared widths, address map and state encodings for the main-bus fabric.
// Main-bus addresses are word addresses, so bit 0 of a field is byte address bit 1.
package bus_pkg;

	localparam int MBUS_AW = 23;
	localparam int ZBUS_AW = 15;
	localparam int BANK_W  = 9;
	localparam int WRAM_AW = 15;
	localparam int ZRAM_AW = 13;

	typedef logic [15:0]        word_t;
	typedef logic [7:0]         byte_t;
	typedef logic [MBUS_AW-1:0] mbus_addr_t;
	typedef logic [15:0]        z80_addr_t;

	// CPU phase enables
	localparam int CPU_CE_PERIOD = 7;
	localparam int CPU_CE_MID    = 3;
	localparam int CE_CNT_W      = $clog2(CPU_CE_PERIOD);

	// Open bus; the LFSR seed must not be all ones
	localparam logic [16:0] NOISE_SEED    = 17'h1B5A3;
	localparam byte_t       OPEN_BUS_BYTE = 8'hFF;

	// --------------------------------------------------------------------
	// Address map fields
	// --------------------------------------------------------------------
	localparam logic [3:0]  ROM_END_NIBBLE = 4'hA;
	localparam logic [7:0]  ZBUS_PAGE      = 8'hA0;
	localparam logic [11:0] CTRL_PAGE      = 12'hA11;
	localparam logic [2:0]  WRAM_PAGE      = 3'b111;
	localparam logic [6:0]  ZBANK_PAGE     = 7'h60;
	localparam logic [6:0]  Z80_HIGH_PAGE  = 7'h7F;
	localparam logic [15:0] Z80_LOW_WINDOW = 16'hC000;

	localparam logic [3:0]  CTRL_BUSREQ_SEL     = 4'h1;
	localparam logic [3:0]  CTRL_RESET_SEL      = 4'h2;
	localparam int          Z80_MBUS_WINDOW_BIT = 15;
	localparam logic [BANK_W-1:0] BANK_RESET    = '0;

	typedef enum logic [2:0] {
		MBUS_IDLE,
		MBUS_SELECT,
		MBUS_RAM_READ,
		MBUS_ROM_READ,
		MBUS_ZBUS_PRE,
		MBUS_ZBUS_READ,
		MBUS_FINISH
	} mstate_t;

	typedef enum logic {MSRC_M68K, MSRC_Z80} msrc_t;

	typedef enum logic [1:0] {ZBUS_IDLE, ZBUS_READ, ZBUS_FINISH} zstate_t;

	typedef enum logic {ZSRC_MBUS, ZSRC_Z80} zsrc_t;

endpackage

/* design/bus_system.sv */
// Main-bus fabric top; ROM is an external responder on a toggle handshake
`timescale 1ns/10ps

module bus_system (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                m68k_as_n,
	input  logic                m68k_rnw,
	input  logic                m68k_uds_n,
	input  logic                m68k_lds_n,
	input  bus_pkg::mbus_addr_t m68k_addr,
	input  bus_pkg::word_t      m68k_wdata,
	output bus_pkg::word_t      m68k_rdata,
	output logic                m68k_dtack_n,
	input  logic                z80_io,
	input  logic                z80_wr_n,
	input  bus_pkg::z80_addr_t  z80_addr,
	input  bus_pkg::byte_t      z80_wdata,
	output bus_pkg::byte_t      z80_rdata,
	output logic                z80_dtack_n,
	output bus_pkg::mbus_addr_t rom_addr,
	input  bus_pkg::word_t      rom_data,
	output logic                rom_req,
	input  logic                rom_ack,
	output logic                z80_reset_n,
	output logic                z80_busreq_n,
	output logic                cpu_ce_p,
	output logic                cpu_ce_n
);

	bus_pkg::word_t no_data;

	zbus_if zb ();

	clock_enables u_clock_enables (
		.MCLK     (MCLK),
		.reset    (reset),
		.cpu_ce_p (cpu_ce_p),
		.cpu_ce_n (cpu_ce_n)
	);

	bus_noise u_bus_noise (
		.MCLK    (MCLK),
		.reset   (reset),
		.step    (cpu_ce_p),
		.no_data (no_data)
	);

	main_bus_arbiter u_main_bus_arbiter (
		.MCLK         (MCLK),
		.reset        (reset),
		.cpu_ce_n     (cpu_ce_n),
		.m68k_as_n    (m68k_as_n),
		.m68k_rnw     (m68k_rnw),
		.m68k_uds_n   (m68k_uds_n),
		.m68k_lds_n   (m68k_lds_n),
		.m68k_addr    (m68k_addr),
		.m68k_wdata   (m68k_wdata),
		.m68k_rdata   (m68k_rdata),
		.m68k_dtack_n (m68k_dtack_n),
		.z80_rnw      (z80_wr_n),
		.z80_addr     (z80_addr),
		.z80_wdata    (z80_wdata),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.no_data      (no_data),
		.z80_reset_n  (z80_reset_n),
		.z80_busreq_n (z80_busreq_n),
		.zb           (zb.mbus)
	);

	zbus_arbiter u_zbus_arbiter (
		.MCLK        (MCLK),
		.reset       (reset),
		.z80_io      (z80_io),
		.z80_wr_n    (z80_wr_n),
		.z80_addr    (z80_addr),
		.z80_wdata   (z80_wdata),
		.z80_rdata   (z80_rdata),
		.z80_dtack_n (z80_dtack_n),
		.zb          (zb.zbus)
	);

endmodule

/* design/clock_enables.sv */
// Both enables are held high in reset so the CPU keeps stepping through it
`timescale 1ns/10ps

module clock_enables (
	input  logic MCLK,
	input  logic reset,
	output logic cpu_ce_p,
	output logic cpu_ce_n
);

	logic [bus_pkg::CE_CNT_W-1:0] cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cnt      <= '0;
			cpu_ce_p <= 1'b1;
			cpu_ce_n <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			if (cnt == bus_pkg::CE_CNT_W'(bus_pkg::CPU_CE_PERIOD - 1)) begin
				cnt <= '0;
			end
			// Phase 1 lands on count 0, phase 2 on CPU_CE_MID
			cpu_ce_p <= (cnt == bus_pkg::CE_CNT_W'(bus_pkg::CPU_CE_PERIOD - 1));
			cpu_ce_n <= (cnt == bus_pkg::CE_CNT_W'(bus_pkg::CPU_CE_MID - 1));
		end
	end

endmodule

/* design/main_bus_arbiter.sv */
// One main-bus cycle at a time; the 68000 starts only on cpu_ce_n
// Work RAM, control page and unmapped space all finish 3 clocks after acceptance
`timescale 1ns/10ps

module main_bus_arbiter (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                cpu_ce_n,
	input  logic                m68k_as_n,
	input  logic                m68k_rnw,
	input  logic                m68k_uds_n,
	input  logic                m68k_lds_n,
	input  bus_pkg::mbus_addr_t m68k_addr,
	input  bus_pkg::word_t      m68k_wdata,
	output bus_pkg::word_t      m68k_rdata,
	output logic                m68k_dtack_n,
	input  logic                z80_rnw,
	input  bus_pkg::z80_addr_t  z80_addr,
	input  bus_pkg::byte_t      z80_wdata,
	output bus_pkg::mbus_addr_t rom_addr,
	input  bus_pkg::word_t      rom_data,
	output logic                rom_req,
	input  logic                rom_ack,
	input  bus_pkg::word_t      no_data,
	output logic                z80_reset_n,
	output logic                z80_busreq_n,
	zbus_if.mbus                zb
);

	bus_pkg::mstate_t    mstate;
	bus_pkg::msrc_t      msrc;
	bus_pkg::mbus_addr_t mbus_a;
	bus_pkg::word_t      mbus_do;
	logic                mbus_rnw;
	logic                mbus_uds_n;
	logic                mbus_lds_n;
	bus_pkg::word_t      data;
	logic                ram_sel;
	logic                ctrl_sel;
	logic                zbus_sel;
	bus_pkg::byte_t      z80_data;
	logic                z80_dtack_n;
	bus_pkg::word_t      ram_q;
	logic                wram_we_hi;
	logic                wram_we_lo;
	logic [3:0]          ctrl_field;
	logic                ctrl_bit;
	bus_pkg::word_t      ctrl_do;

	assign rom_addr = mbus_a;

	// Sub-bus byte address uses UDS as byte address bit 0
	assign zb.sel              = zbus_sel;
	assign zb.addr             = {mbus_a[13:0], mbus_uds_n};
	assign zb.wdata            = mbus_uds_n ? mbus_do[7:0] : mbus_do[15:8];
	assign zb.rnw              = mbus_rnw;
	assign zb.zbus_free        = ~z80_busreq_n & z80_reset_n;
	assign zb.z80_mbus_data    = z80_data;
	assign zb.z80_mbus_dtack_n = z80_dtack_n;

	// --------------------------------------------------------------------
	// Work RAM, E00000-FFFFFF, one RAM per byte lane
	// --------------------------------------------------------------------
	assign wram_we_hi = ram_sel & ~mbus_rnw & ~mbus_uds_n;
	assign wram_we_lo = ram_sel & ~mbus_rnw & ~mbus_lds_n;

	sync_ram #(.ADDR_BITS(bus_pkg::WRAM_AW)) wram_hi (
		.MCLK  (MCLK),
		.addr  (mbus_a[bus_pkg::WRAM_AW-1:0]),
		.wdata (mbus_do[15:8]),
		.we    (wram_we_hi),
		.rdata (ram_q[15:8])
	);

	sync_ram #(.ADDR_BITS(bus_pkg::WRAM_AW)) wram_lo (
		.MCLK  (MCLK),
		.addr  (mbus_a[bus_pkg::WRAM_AW-1:0]),
		.wdata (mbus_do[7:0]),
		.we    (wram_we_lo),
		.rdata (ram_q[7:0])
	);

	// --------------------------------------------------------------------
	// Z80 control register, A11100 and A11200
	// --------------------------------------------------------------------
	assign ctrl_field = mbus_a[10:7];

	always_comb begin
		ctrl_bit = no_data[8];
		if (ctrl_field == bus_pkg::CTRL_BUSREQ_SEL) begin
			ctrl_bit = z80_busreq_n;
		end else if (ctrl_field == bus_pkg::CTRL_RESET_SEL) begin
			ctrl_bit = z80_reset_n;
		end
	end

	assign ctrl_do = {no_data[15:9], ctrl_bit, no_data[7:0]};

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else if (ctrl_sel && !mbus_rnw && !mbus_uds_n) begin
			if (ctrl_field == bus_pkg::CTRL_BUSREQ_SEL) begin
				z80_busreq_n <= ~mbus_do[8];
			end
			if (ctrl_field == bus_pkg::CTRL_RESET_SEL) begin
				z80_reset_n <= mbus_do[8];
			end
		end
	end

	// --------------------------------------------------------------------
	// Main-bus FSM
	// --------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate       <= bus_pkg::MBUS_IDLE;
			msrc         <= bus_pkg::MSRC_M68K;
			m68k_dtack_n <= 1'b1;
			z80_dtack_n  <= 1'b1;
			zbus_sel     <= 1'b0;
			ram_sel      <= 1'b0;
			ctrl_sel     <= 1'b0;
			rom_req      <= 1'b0;
		end else begin
			if (m68k_as_n) begin
				m68k_dtack_n <= 1'b1;
			end
			if (!zb.z80_mbus_req) begin
				z80_dtack_n <= 1'b1;
			end

			case (mstate)
				bus_pkg::MBUS_IDLE: begin
					if (!m68k_as_n && m68k_dtack_n && cpu_ce_n) begin
						msrc       <= bus_pkg::MSRC_M68K;
						mbus_a     <= m68k_addr;
						mbus_do    <= m68k_wdata;
						mbus_rnw   <= m68k_rnw;
						mbus_uds_n <= m68k_uds_n;
						mbus_lds_n <= m68k_lds_n;
						mstate     <= bus_pkg::MBUS_SELECT;
					end else if (zb.z80_mbus_req && z80_dtack_n) begin
						msrc <= bus_pkg::MSRC_Z80;
						// Banked 32 KB window, else the C000xx page
						if (z80_addr[bus_pkg::Z80_MBUS_WINDOW_BIT]) begin
							mbus_a <= {zb.bank, z80_addr[14:1]};
						end else begin
							mbus_a <= {bus_pkg::Z80_LOW_WINDOW, z80_addr[7:1]};
						end
						mbus_do    <= {z80_wdata, z80_wdata};
						mbus_rnw   <= z80_rnw;
						mbus_uds_n <= z80_addr[0];
						mbus_lds_n <= ~z80_addr[0];
						mstate     <= bus_pkg::MBUS_SELECT;
					end
				end

				bus_pkg::MBUS_SELECT: begin
					// Unmapped space falls through to the local read path
					mstate <= bus_pkg::MBUS_RAM_READ;
					if (mbus_a[22:19] < bus_pkg::ROM_END_NIBBLE) begin
						rom_req <= ~rom_ack;
						mstate  <= bus_pkg::MBUS_ROM_READ;
					end else if (mbus_a[22:15] == bus_pkg::ZBUS_PAGE) begin
						mstate <= bus_pkg::MBUS_ZBUS_PRE;
					end else if (mbus_a[22:11] == bus_pkg::CTRL_PAGE && mbus_a[6:0] == '0) begin
						ctrl_sel <= 1'b1;
					end else if (mbus_a[22:20] == bus_pkg::WRAM_PAGE) begin
						ram_sel <= 1'b1;
					end
				end

				bus_pkg::MBUS_RAM_READ: begin
					ram_sel  <= 1'b0;
					ctrl_sel <= 1'b0;
					if (ram_sel) begin
						data <= ram_q;
					end else if (ctrl_sel) begin
						data <= ctrl_do;
					end else begin
						data <= no_data;
					end
					mstate <= bus_pkg::MBUS_FINISH;
				end

				bus_pkg::MBUS_ROM_READ: begin
					if (rom_req == rom_ack) begin
						data   <= rom_data;
						mstate <= bus_pkg::MBUS_FINISH;
					end
				end

				bus_pkg::MBUS_ZBUS_PRE: begin
					zbus_sel <= 1'b1;
					mstate   <= bus_pkg::MBUS_ZBUS_READ;
				end

				bus_pkg::MBUS_ZBUS_READ: begin
					if (!zb.dtack_n) begin
						zbus_sel <= 1'b0;
						data     <= {zb.rdata, zb.rdata};
						mstate   <= bus_pkg::MBUS_FINISH;
					end
				end

				bus_pkg::MBUS_FINISH: begin
					if (msrc == bus_pkg::MSRC_M68K) begin
						m68k_rdata   <= data;
						m68k_dtack_n <= 1'b0;
					end else begin
						// Even Z80 addresses sit on the upper lane
						z80_data    <= z80_addr[0] ? data[7:0] : data[15:8];
						z80_dtack_n <= 1'b0;
					end
					mstate <= bus_pkg::MBUS_IDLE;
				end

				default: mstate <= bus_pkg::MBUS_IDLE;
			endcase
		end
	end

endmodule

/* design/sync_ram.sv */
// Read data appears one clock after the address; a write returns the old byte
`timescale 1ns/10ps

module sync_ram #(
	parameter int ADDR_BITS = 13
) (
	input  logic                 MCLK,
	input  logic [ADDR_BITS-1:0] addr,
	input  bus_pkg::byte_t       wdata,
	input  logic                 we,
	output bus_pkg::byte_t       rdata
);

	bus_pkg::byte_t mem [2**ADDR_BITS];

	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

/* design/zbus_arbiter.sv */
// Main-bus requests win over local Z80 requests; Z80 RAM mirrors every 8 KB
// Z80 addresses 7F00-FFFF are passed on to the main bus
`timescale 1ns/10ps

module zbus_arbiter (
	input  logic               MCLK,
	input  logic               reset,
	input  logic               z80_io,
	input  logic               z80_wr_n,
	input  bus_pkg::z80_addr_t z80_addr,
	input  bus_pkg::byte_t     z80_wdata,
	output bus_pkg::byte_t     z80_rdata,
	output logic               z80_dtack_n,
	zbus_if.zbus               zb
);

	bus_pkg::zstate_t            zstate;
	bus_pkg::zsrc_t              zsrc;
	logic [bus_pkg::ZBUS_AW-1:0] zbus_a;
	bus_pkg::byte_t              zbus_do;
	logic                        zbus_we;
	bus_pkg::byte_t              zram_q;
	bus_pkg::byte_t              zbus_di;
	logic                        zram_sel;
	logic                        bank_sel;
	logic                        z80_local;
	logic                        z80_zsel;
	bus_pkg::byte_t              mbus_data;
	logic                        mbus_dtack_n;
	bus_pkg::byte_t              z80_zdata;
	logic                        z80_zdtack_n;
	logic [bus_pkg::BANK_W-1:0]  bank;

	// Local Z80 space is 0000-7EFF
	assign z80_local       = ~z80_addr[15] & (z80_addr[14:8] != bus_pkg::Z80_HIGH_PAGE);
	assign z80_zsel        = z80_io & z80_local;
	assign zb.z80_mbus_req = z80_io & ~z80_local;

	assign zb.rdata   = mbus_data;
	assign zb.dtack_n = mbus_dtack_n;
	assign zb.bank    = bank;

	// Answers from both buses merged for the Z80
	assign z80_rdata   = !z80_zdtack_n ? z80_zdata : zb.z80_mbus_data;
	assign z80_dtack_n = z80_zdtack_n & zb.z80_mbus_dtack_n;

	// RAM at 0000-3FFF, everything else on the sub-bus reads open bus
	assign zram_sel = ~zbus_a[14];
	assign zbus_di  = zram_sel ? zram_q : bus_pkg::OPEN_BUS_BYTE;

	sync_ram #(.ADDR_BITS(bus_pkg::ZRAM_AW)) zram (
		.MCLK  (MCLK),
		.addr  (zbus_a[bus_pkg::ZRAM_AW-1:0]),
		.wdata (zbus_do),
		.we    (zbus_we & zram_sel),
		.rdata (zram_q)
	);

	// --------------------------------------------------------------------
	// Sub-bus FSM
	// --------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate       <= bus_pkg::ZBUS_IDLE;
			zsrc         <= bus_pkg::ZSRC_MBUS;
			zbus_we      <= 1'b0;
			mbus_dtack_n <= 1'b1;
			z80_zdtack_n <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!zb.sel) begin
				mbus_dtack_n <= 1'b1;
			end
			if (!z80_zsel) begin
				z80_zdtack_n <= 1'b1;
			end

			case (zstate)
				bus_pkg::ZBUS_IDLE: begin
					if (zb.sel && mbus_dtack_n) begin
						zbus_a  <= zb.addr;
						zbus_do <= zb.wdata;
						// 68000 writes land only while the Z80 is off the bus
						zbus_we <= ~zb.rnw & zb.zbus_free;
						zsrc    <= bus_pkg::ZSRC_MBUS;
						zstate  <= bus_pkg::ZBUS_READ;
					end else if (z80_zsel && z80_zdtack_n) begin
						zbus_a  <= z80_addr[bus_pkg::ZBUS_AW-1:0];
						zbus_do <= z80_wdata;
						zbus_we <= ~z80_wr_n;
						zsrc    <= bus_pkg::ZSRC_Z80;
						zstate  <= bus_pkg::ZBUS_READ;
					end
				end

				bus_pkg::ZBUS_READ: zstate <= bus_pkg::ZBUS_FINISH;

				bus_pkg::ZBUS_FINISH: begin
					if (zsrc == bus_pkg::ZSRC_MBUS) begin
						mbus_data    <= zb.zbus_free ? zbus_di : bus_pkg::OPEN_BUS_BYTE;
						mbus_dtack_n <= 1'b0;
					end else begin
						z80_zdata    <= zbus_di;
						z80_zdtack_n <= 1'b0;
					end
					zstate <= bus_pkg::ZBUS_IDLE;
				end

				default: zstate <= bus_pkg::ZBUS_IDLE;
			endcase
		end
	end

	// --------------------------------------------------------------------
	// Bank register at 6000-60FF, loaded one bit per write from the top
	// --------------------------------------------------------------------
	assign bank_sel = (zbus_a[14:8] == bus_pkg::ZBANK_PAGE);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= bus_pkg::BANK_RESET;
		end else if (bank_sel && zbus_we) begin
			bank <= {zbus_do[0], bank[bus_pkg::BANK_W-1:1]};
		end
	end

endmodule

/* design/zbus_if.sv */
// Link between the main-bus arbiter and the Z80 sub-bus arbiter
`timescale 1ns/10ps

interface zbus_if;

	// Main bus into the sub-bus
	logic                        sel;
	logic [bus_pkg::ZBUS_AW-1:0] addr;
	bus_pkg::byte_t              wdata;
	logic                        rnw;
	logic                        zbus_free;

	// Main-bus answer to a Z80 request
	bus_pkg::byte_t              z80_mbus_data;
	logic                        z80_mbus_dtack_n;

	// Sub-bus answer and Z80 side requests
	bus_pkg::byte_t              rdata;
	logic                        dtack_n;
	logic [bus_pkg::BANK_W-1:0]  bank;
	logic                        z80_mbus_req;

	modport mbus (
		output sel, addr, wdata, rnw, zbus_free, z80_mbus_data, z80_mbus_dtack_n,
		input  rdata, dtack_n, bank, z80_mbus_req
	);

	modport zbus (
		input  sel, addr, wdata, rnw, zbus_free, z80_mbus_data, z80_mbus_dtack_n,
		output rdata, dtack_n, bank, z80_mbus_req
	);

endinterface

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; exit status is nonzero unless the testbench passes
verilator --binary --assert --timescale 1ns/10ps --top-module bus_system_tb -f vlog.f \
	&& out=$(./obj_dir/Vbus_system_tb) \
	&& echo "$out" \
	&& echo "$out" | grep -q "TEST PASSED" \
	|| exit 1

/* verification/bus_system_tb.sv */
// Testbench for the main-bus fabric, with a toggle-handshake ROM responder
// Work RAM and Z80 RAM start uninitialized, so every RAM read follows a write
`timescale 1ns/10ps

module bus_system_tb;

	localparam logic [15:0] ROM_XOR        = 16'h5A3C;
	localparam logic [8:0]  BANK_E00000    = 9'h1C0;
	localparam int          TIMEOUT_CYCLES = 4000;

	logic                MCLK    = 1'b0;
	logic                reset;
	logic                m68k_as_n;
	logic                m68k_rnw;
	logic                m68k_uds_n;
	logic                m68k_lds_n;
	bus_pkg::mbus_addr_t m68k_addr;
	bus_pkg::word_t      m68k_wdata;
	bus_pkg::word_t      m68k_rdata;
	logic                m68k_dtack_n;
	logic                z80_io;
	logic                z80_wr_n;
	bus_pkg::z80_addr_t  z80_addr;
	bus_pkg::byte_t      z80_wdata;
	bus_pkg::byte_t      z80_rdata;
	logic                z80_dtack_n;
	bus_pkg::mbus_addr_t rom_addr;
	bus_pkg::word_t      rom_data = '0;
	logic                rom_req;
	logic                rom_ack  = 1'b0;
	logic                z80_reset_n;
	logic                z80_busreq_n;
	logic                cpu_ce_p;
	logic                cpu_ce_n;

	integer seed = 1493;
	int     rom_delays [16];
	int     rom_acks    = 0;
	int     cycles      = 0;
	int     ce_phase    = 0;
	int     checks      = 0;
	int     errors      = 0;
	int     prop_errors = 0;
	int     test_checks = 0;
	int     test_errors = 0;

	always #10 MCLK = ~MCLK;

	bus_system DUT (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.m68k_rnw     (m68k_rnw),
		.m68k_uds_n   (m68k_uds_n),
		.m68k_lds_n   (m68k_lds_n),
		.m68k_addr    (m68k_addr),
		.m68k_wdata   (m68k_wdata),
		.m68k_rdata   (m68k_rdata),
		.m68k_dtack_n (m68k_dtack_n),
		.z80_io       (z80_io),
		.z80_wr_n     (z80_wr_n),
		.z80_addr     (z80_addr),
		.z80_wdata    (z80_wdata),
		.z80_rdata    (z80_rdata),
		.z80_dtack_n  (z80_dtack_n),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.z80_reset_n  (z80_reset_n),
		.z80_busreq_n (z80_busreq_n),
		.cpu_ce_p     (cpu_ce_p),
		.cpu_ce_n     (cpu_ce_n)
	);

	// ----------------------------------------------------------------------
	// ROM responder echoing rom_req after 1 to 8 clocks
	// ----------------------------------------------------------------------
	always begin
		@(negedge MCLK);
		if (!reset && rom_req !== rom_ack) begin
			repeat (rom_delays[rom_acks % 16]) @(negedge MCLK);
			rom_data = rom_addr[15:0] ^ ROM_XOR;
			rom_ack  = rom_req;
			rom_acks = rom_acks + 1;
		end
	end

	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// CPU cycle of 7 clocks counted from the release of reset
	always @(posedge MCLK) begin
		if (reset || ce_phase == bus_pkg::CPU_CE_PERIOD - 1) begin
			ce_phase <= 0;
		end else begin
			ce_phase <= ce_phase + 1;
		end
	end

	// Phase 1 opens the CPU cycle and phase 2 follows three clocks later
	ce_phase_check: assert property (@(posedge MCLK) disable iff (reset)
		!$past(reset) |-> (cpu_ce_p == (ce_phase == 0)
			&& cpu_ce_n == (ce_phase == bus_pkg::CPU_CE_MID)))
	else begin
		prop_errors++;
		$display("cpu_ce_p or cpu_ce_n pulsed outside its slot in the CPU cycle");
	end

	// DTACK returns high one clock after the master lets go
	m68k_dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		(m68k_as_n && !m68k_dtack_n) |=> m68k_dtack_n)
	else begin
		prop_errors++;
		$display("m68k_dtack_n stayed low after AS was released");
	end

	z80_dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		(!z80_io && !z80_dtack_n) |=> z80_dtack_n)
	else begin
		prop_errors++;
		$display("z80_dtack_n stayed low after the Z80 request was dropped");
	end

	// Request and address hold still while the ROM owes an answer
	rom_request_hold: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != rom_ack) |=> ($stable(rom_req) && $stable(rom_addr)))
	else begin
		prop_errors++;
		$display("rom_req or rom_addr changed before rom_ack answered");
	end

	// ----------------------------------------------------------------------
	// Master tasks and checks
	// ----------------------------------------------------------------------
	task automatic m68k_cycle(input logic [23:0] byte_addr, input logic rnw, input logic uds_n,
		input logic lds_n, input bus_pkg::word_t wdata, output bus_pkg::word_t rdata);
		@(negedge MCLK);
		m68k_addr  = byte_addr[23:1];
		m68k_rnw   = rnw;
		m68k_uds_n = uds_n;
		m68k_lds_n = lds_n;
		m68k_wdata = wdata;
		m68k_as_n  = 1'b0;
		@(negedge MCLK);
		while (m68k_dtack_n) @(negedge MCLK);
		rdata      = m68k_rdata;
		m68k_as_n  = 1'b1;
		m68k_rnw   = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
	endtask

	task automatic z80_cycle(input logic [15:0] addr, input logic wr_n,
		input bus_pkg::byte_t wdata, output bus_pkg::byte_t rdata);
		@(negedge MCLK);
		z80_addr  = addr;
		z80_wr_n  = wr_n;
		z80_wdata = wdata;
		z80_io    = 1'b1;
		@(negedge MCLK);
		while (z80_dtack_n) @(negedge MCLK);
		rdata    = z80_rdata;
		z80_io   = 1'b0;
		z80_wr_n = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - test_checks,
			(errors + prop_errors) - test_errors);
		test_checks = checks;
		test_errors = errors + prop_errors;
	endtask

	initial begin : main_sequence
		logic [31:0]    rnd;
		logic [15:0]    off;
		logic [23:0]    rom_byte_addr;
		bus_pkg::word_t rd;
		bus_pkg::word_t w1;
		bus_pkg::word_t ram_word;
		bus_pkg::byte_t nb;
		bus_pkg::byte_t zbyte;
		bus_pkg::byte_t zrd;
		int             acks_before;
		logic           req_before;

		reset      = 1'b1;
		m68k_as_n  = 1'b1;
		m68k_rnw   = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_addr  = '0;
		m68k_wdata = '0;
		z80_io     = 1'b0;
		z80_wr_n   = 1'b1;
		z80_addr   = '0;
		z80_wdata  = '0;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			rom_delays[i] = int'(rnd[2:0]) + 1;
		end
		repeat (10) @(negedge MCLK);
		reset = 1'b0;
		repeat (2) @(negedge MCLK);

		// Reset state
		check_value("m68k_dtack_n", 24'(m68k_dtack_n), 24'h1);
		check_value("z80_dtack_n", 24'(z80_dtack_n), 24'h1);
		check_value("rom_req", 24'(rom_req), 24'h0);
		check_value("z80_busreq_n", 24'(z80_busreq_n), 24'h1);
		check_value("z80_reset_n", 24'(z80_reset_n), 24'h0);
		m68k_cycle(24'hA11100, 1'b1, 1'b0, 1'b0, 16'h0000, rd);
		check_value("m68k_rdata[8]", 24'(rd[8]), 24'h1);
		finish_test("reset state");

		// Work RAM full word then upper lane alone
		rnd = $random(seed);
		w1  = rnd[15:0];
		rnd = $random(seed);
		off = {1'b0, rnd[14:1], 1'b0};
		rnd = $random(seed);
		nb  = rnd[7:0];
		m68k_cycle({BANK_E00000, off[14:0]}, 1'b0, 1'b0, 1'b0, w1, rd);
		m68k_cycle({BANK_E00000, off[14:0]}, 1'b0, 1'b0, 1'b1, {nb, ~w1[7:0]}, rd);
		m68k_cycle({BANK_E00000, off[14:0]}, 1'b1, 1'b0, 1'b0, 16'h0000, rd);
		ram_word = {nb, w1[7:0]};
		check_value("m68k_rdata", 24'(rd), 24'(ram_word));
		finish_test("work ram lanes");

		for (int i = 0; i < 4; i++) begin
			rnd           = $random(seed);
			rom_byte_addr = {4'h0, rnd[19:1], 1'b0};
			acks_before   = rom_acks;
			req_before    = rom_req;
			m68k_cycle(rom_byte_addr, 1'b1, 1'b0, 1'b0, 16'h0000, rd);
			check_value("rom_addr", 24'(rom_addr), 24'(rom_byte_addr[23:1]));
			check_value("m68k_rdata", 24'(rd), 24'(rom_byte_addr[16:1] ^ ROM_XOR));
			check_value("rom_req", 24'(rom_req), 24'(!req_before));
			check_value("rom_ack count", 24'(rom_acks - acks_before), 24'd1);
		end
		finish_test("rom handshake");

		// Sub-bus closed while the Z80 holds it
		// The Z80 plants a byte that the blocked 68000 write must leave alone
		z80_cycle(16'h0010, 1'b0, 8'hC3, zrd);
		m68k_cycle(24'hA00010, 1'b0, 1'b0, 1'b1, 16'h5A00, rd);
		m68k_cycle(24'hA00010, 1'b1, 1'b0, 1'b1, 16'h0000, rd);
		check_value("m68k_rdata[15:8]", 24'(rd[15:8]), 24'hFF);
		m68k_cycle(24'hA11100, 1'b0, 1'b0, 1'b0, 16'h0100, rd);
		m68k_cycle(24'hA11200, 1'b0, 1'b0, 1'b0, 16'h0100, rd);
		check_value("z80_busreq_n", 24'(z80_busreq_n), 24'h0);
		check_value("z80_reset_n", 24'(z80_reset_n), 24'h1);
		m68k_cycle(24'hA00010, 1'b1, 1'b0, 1'b1, 16'h0000, rd);
		check_value("m68k_rdata[15:8]", 24'(rd[15:8]), 24'hC3);
		rnd   = $random(seed);
		zbyte = rnd[7:0];
		m68k_cycle(24'hA00010, 1'b0, 1'b0, 1'b1, {zbyte, 8'h00}, rd);
		m68k_cycle(24'hA00010, 1'b1, 1'b0, 1'b1, 16'h0000, rd);
		check_value("m68k_rdata[15:8]", 24'(rd[15:8]), 24'(zbyte));
		z80_cycle(16'h0010, 1'b1, 8'h00, zrd);
		check_value("z80_rdata", 24'(zrd), 24'(zbyte));
		finish_test("sub-bus gating");

		// Bank bits go in lowest first
		for (int i = 0; i < 9; i++) begin
			z80_cycle(16'h6000, 1'b0, {7'h00, BANK_E00000[i]}, zrd);
		end
		z80_cycle({1'b1, off[14:0]}, 1'b1, 8'h00, zrd);
		check_value("z80_rdata", 24'(zrd), 24'(ram_word[15:8]));
		z80_cycle({1'b1, off[14:1], 1'b1}, 1'b1, 8'h00, zrd);
		check_value("z80_rdata", 24'(zrd), 24'(ram_word[7:0]));
		finish_test("z80 bank window");

		acks_before = rom_acks;
		req_before  = rom_req;
		m68k_cycle(24'hB00000, 1'b1, 1'b0, 1'b0, 16'h0000, rd);
		check_value("rom_req", 24'(rom_req), 24'(req_before));
		check_value("rom_ack count", 24'(rom_acks - acks_before), 24'd0);
		finish_test("unmapped access");

		$display("Summary: %0d checks, %0d errors", checks, errors + prop_errors);
		if (errors + prop_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
design/bus_pkg.sv
design/zbus_if.sv
design/clock_enables.sv
design/bus_noise.sv
design/sync_ram.sv
design/main_bus_arbiter.sv
design/zbus_arbiter.sv
design/bus_system.sv
verification/bus_system_tb.sv
